// ==== sim.f ====
+incdir+source
source/usb_proto_pkg.sv
source/proxy_pkg.sv
source/proxy_fsm.sv
source/capture_logger.sv
source/link_status.sv
source/usb_proxy_top.sv
bench/tb_clock_gen.sv
bench/tb_usb_proxy.sv

// ==== Bender.yml ====
package:
  name: usb_proxy

sources:
  - include_dirs:
      - source
    files:
      - source/usb_proto_pkg.sv
      - source/proxy_pkg.sv
      - source/proxy_fsm.sv
      - source/capture_logger.sv
      - source/link_status.sv
      - source/usb_proxy_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_usb_proxy.sv

// ==== bench/tb_usb_proxy.sv ====
/* USB proxy testbench
   Directed tests for forwarding, logging, back-pressure and link status */

`timescale 1ns/1ps

`include "usb_proxy_consts.svh"

module tb_usb_proxy;

    import usb_proto_pkg::*;
    import proxy_pkg::*;

    logic                   clk;
    logic                   rst_n;

    logic [`USB_DATA_W-1:0] host_rx_data;
    logic                   host_rx_valid;
    logic                   host_rx_sop;
    logic                   host_rx_eop;
    usb_pid_e               host_rx_pid;
    logic                   host_rx_crc_valid;
    logic [`USB_DATA_W-1:0] host_tx_data;
    logic                   host_tx_valid;
    logic                   host_tx_sop;
    logic                   host_tx_eop;
    usb_pid_e               host_tx_pid;

    logic [`USB_DATA_W-1:0] device_rx_data;
    logic                   device_rx_valid;
    logic                   device_rx_sop;
    logic                   device_rx_eop;
    usb_pid_e               device_rx_pid;
    logic                   device_rx_crc_valid;
    logic [`USB_DATA_W-1:0] device_tx_data;
    logic                   device_tx_valid;
    logic                   device_tx_sop;
    logic                   device_tx_eop;
    usb_pid_e               device_tx_pid;

    logic                   buffer_valid;
    logic [`USB_DATA_W-1:0] buffer_data;
    log_flags_t             buffer_flags;
    logic [`TS_W-1:0]       buffer_timestamp;
    logic                   buffer_ready;
    logic [`TS_W-1:0]       timestamp;

    logic [1:0]             device_line_state;
    logic                   event_valid;
    logic [`EVT_W-1:0]      event_type;
    logic                   proxy_enable;
    logic [7:0]             status_register;

    int error_count;
    int check_count;
    int test_count;
    int test_errors;    // Error count when the current test began

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    usb_proxy_top i_usb_proxy_top (.*);

    // Free running time base, moves every cycle
    always @(negedge clk) begin
        timestamp <= timestamp + 64'd3;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Check and bookkeeping helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_equal(input string test, input string what,
                                input logic [`TS_W-1:0] expected,
                                input logic [`TS_W-1:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] %s: %s expected %0h actual %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic open_test();
        test_errors = error_count;
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("%-16s finished, %0d errors", name, error_count - test_errors);
    endtask

    function automatic logic [7:0] status_word(input logic [1:0] speed, input bit en,
                                               input bit crc, input bit conn);
        return {speed, 3'b000, en, crc, conn};  // Layout of the status byte
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Packet drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic release_rx_lines();
        host_rx_valid       = 1'b0;
        host_rx_sop         = 1'b0;
        host_rx_eop         = 1'b0;
        host_rx_crc_valid   = 1'b1;
        device_rx_valid     = 1'b0;
        device_rx_sop       = 1'b0;
        device_rx_eop       = 1'b0;
        device_rx_crc_valid = 1'b1;
    endtask

    task automatic drive_beat(input bit from_host, input logic [7:0] data,
                              input bit sop, input bit eop, input usb_pid_e pid);
        if (from_host) begin
            host_rx_data  = data;
            host_rx_valid = 1'b1;
            host_rx_sop   = sop;
            host_rx_eop   = eop;
            host_rx_pid   = pid;
        end else begin
            device_rx_data  = data;
            device_rx_valid = 1'b1;
            device_rx_sop   = sop;
            device_rx_eop   = eop;
            device_rx_pid   = pid;
        end
    endtask

    // Zero latency copy on the opposite tx side, other side stays quiet
    task automatic check_forwarding(input string test, input bit from_host,
                                    input logic [7:0] data, input bit sop, input bit eop,
                                    input usb_pid_e pid, input bit expected);
        if (from_host) begin
            expect_equal(test, "device_tx_valid", expected, device_tx_valid);
            expect_equal(test, "host_tx_valid", 1'b0, host_tx_valid);
            if (expected) begin
                expect_equal(test, "device_tx_data", data, device_tx_data);
                expect_equal(test, "device_tx_sop", sop, device_tx_sop);
                expect_equal(test, "device_tx_eop", eop, device_tx_eop);
                expect_equal(test, "device_tx_pid", pid, device_tx_pid);
            end
        end else begin
            expect_equal(test, "host_tx_valid", expected, host_tx_valid);
            expect_equal(test, "device_tx_valid", 1'b0, device_tx_valid);
            if (expected) begin
                expect_equal(test, "host_tx_data", data, host_tx_data);
                expect_equal(test, "host_tx_sop", sop, host_tx_sop);
                expect_equal(test, "host_tx_eop", eop, host_tx_eop);
                expect_equal(test, "host_tx_pid", pid, host_tx_pid);
            end
        end
    endtask

    task automatic check_log_entry(input string test, input bit expected,
                                   input logic [7:0] data, input usb_pid_e pid,
                                   input bit dir, input logic [`TS_W-1:0] ts);
        expect_equal(test, "buffer_valid", expected, buffer_valid);
        if (expected) begin
            expect_equal(test, "buffer_data", data, buffer_data);
            expect_equal(test, "flags pid", pid, buffer_flags.pid);
            expect_equal(test, "flags dir", dir, buffer_flags.dir);
            expect_equal(test, "flags pad", 3'b000, buffer_flags.pad);
            expect_equal(test, "buffer_timestamp", ts, buffer_timestamp);
        end
    endtask

    // One byte every other cycle, log checked one cycle after each byte
    task automatic send_packet(input string test, input bit from_host, input usb_pid_e pid,
                               input int len, input bit expected);
        logic [7:0]       data;
        logic [`TS_W-1:0] sop_ts;
        int               i;
        sop_ts = '0;
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            data = 8'($urandom_range(0, 255));
            drive_beat(from_host, data, i == 0, i == len - 1, pid);
            #1;
            if (i == 0) sop_ts = timestamp;
            check_forwarding(test, from_host, data, i == 0, i == len - 1, pid, expected);
            @(negedge clk);
            release_rx_lines();
            check_log_entry(test, expected, data, pid, !from_host, sop_ts);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset: rst_n was still low after %0d cycles", cycles);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        open_test();
        expect_equal("reset_values", "host_tx_valid", 1'b0, host_tx_valid);
        expect_equal("reset_values", "device_tx_valid", 1'b0, device_tx_valid);
        expect_equal("reset_values", "buffer_valid", 1'b0, buffer_valid);
        expect_equal("reset_values", "status_register", 8'h00, status_register);
        close_test("reset_values");
    endtask

    task automatic h2d_forwarding();
        open_test();
        send_packet("h2d_forwarding", 1'b1, PID_OUT, 3, 1'b1);
        send_packet("h2d_forwarding", 1'b0, PID_ACK, 1, 1'b1);
        send_packet("h2d_forwarding", 1'b1, PID_DATA0, 8, 1'b1);
        send_packet("h2d_forwarding", 1'b0, PID_ACK, 1, 1'b1);
        close_test("h2d_forwarding");
    endtask

    task automatic device_response();
        open_test();
        send_packet("device_response", 1'b1, PID_IN, 3, 1'b1);
        send_packet("device_response", 1'b0, PID_DATA1, 6, 1'b1);
        // Waiting on the host, device start is ignored
        send_packet("device_response", 1'b0, PID_NAK, 1, 1'b0);
        repeat (`RESP_TIMEOUT) @(negedge clk);
        // Back in idle after the timeout, device start accepted again
        send_packet("device_response", 1'b0, PID_ACK, 1, 1'b1);
        close_test("device_response");
    endtask

    task automatic sof_and_enable();
        open_test();
        send_packet("sof_and_enable", 1'b1, PID_SOF, 3, 1'b0);
        @(negedge clk);
        proxy_enable = 1'b0;
        send_packet("sof_and_enable", 1'b1, PID_OUT, 3, 1'b0);
        @(negedge clk);
        proxy_enable = 1'b1;
        close_test("sof_and_enable");
    endtask

    task automatic back_pressure();
        logic [7:0]       data;
        logic [7:0]       prev_data;
        logic [`TS_W-1:0] sop_ts;
        bit               slot_busy;    // Previous byte went into the log slot
        int               i;
        open_test();
        slot_busy = 1'b0;
        prev_data = '0;
        sop_ts    = '0;
        for (i = 0; i <= 10; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_log_entry("back_pressure", slot_busy, prev_data, PID_DATA0, 1'b0, sop_ts);
            end
            if (i < 10) begin
                data         = 8'($urandom_range(0, 255));
                buffer_ready = !(i >= 3 && i <= 6);
                drive_beat(1'b1, data, i == 0, i == 9, PID_DATA0);
                #1;
                if (i == 0) sop_ts = timestamp;
                check_forwarding("back_pressure", 1'b1, data, i == 0, i == 9, PID_DATA0, 1'b1);
                slot_busy = buffer_ready && !slot_busy;
                prev_data = data;
            end else begin
                release_rx_lines();
                buffer_ready = 1'b1;
            end
        end
        close_test("back_pressure");
    endtask

    // Drive one set of monitor inputs, status checked a cycle later
    task automatic status_step(input logic [1:0] line, input bit ev, input logic [7:0] code,
                               input bit en, input bit bad_crc, input logic [7:0] expected);
        @(negedge clk);
        device_line_state = line;
        event_valid       = ev;
        event_type        = code;
        proxy_enable      = en;
        if (bad_crc) begin
            host_rx_valid     = 1'b1;
            host_rx_eop       = 1'b1;
            host_rx_crc_valid = 1'b0;
        end
        @(negedge clk);
        event_valid = 1'b0;
        release_rx_lines();
        expect_equal("status_bits", "status_register", expected, status_register);
    endtask

    task automatic status_bits();
        open_test();
        status_step(2'b01, 0, 8'd0, 1, 0, status_word(2'd0, 1, 0, 1));
        status_step(2'b01, 1, `EVT_FULL_SPEED, 1, 0, status_word(2'd1, 1, 0, 1));
        status_step(2'b01, 1, `EVT_HIGH_SPEED, 1, 0, status_word(2'd2, 1, 0, 1));
        status_step(2'b01, 1, 8'h07, 1, 0, status_word(2'd2, 1, 0, 1));  // Unknown code
        status_step(2'b00, 0, 8'd0, 1, 0, status_word(2'd2, 1, 0, 0));
        status_step(2'b10, 0, 8'd0, 0, 0, status_word(2'd2, 0, 0, 1));
        status_step(2'b10, 0, 8'd0, 1, 1, status_word(2'd2, 1, 1, 1));
        status_step(2'b10, 1, `EVT_LOW_SPEED, 1, 0, status_word(2'd0, 1, 1, 1));
        status_step(2'b11, 0, 8'd0, 1, 0, status_word(2'd0, 1, 1, 1));  // Error is sticky
        close_test("status_bits");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        test_errors = 0;
        void'($urandom(87789));
        host_rx_data      = '0;
        host_rx_pid       = PID_OUT;
        device_rx_data    = '0;
        device_rx_pid     = PID_ACK;
        release_rx_lines();
        buffer_ready      = 1'b1;
        timestamp         = 64'h0001_0000_0000_0000;
        device_line_state = 2'b00;
        event_valid       = 1'b0;
        event_type        = '0;
        proxy_enable      = 1'b1;

        @(negedge clk);     // Still inside reset
        reset_values();
        wait_reset_release();

        h2d_forwarding();
        device_response();
        sof_and_enable();
        back_pressure();
        status_bits();

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
/* Testbench clock and reset
   20 ns clock, rst_n held low for the first 3 cycles */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;  // Away from the rising edge
    end

endmodule

// ==== source/usb_proxy_top.sv ====
/* USB proxy top level
   Connects the transaction FSM, the capture logger and the link status block */

`timescale 1ns/1ps

`include "usb_proxy_consts.svh"

module usb_proxy_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Host side
    input  logic [`USB_DATA_W-1:0]  host_rx_data,
    input  logic                    host_rx_valid,
    input  logic                    host_rx_sop,
    input  logic                    host_rx_eop,
    input  usb_proto_pkg::usb_pid_e host_rx_pid,
    input  logic                    host_rx_crc_valid,
    output logic [`USB_DATA_W-1:0]  host_tx_data,
    output logic                    host_tx_valid,
    output logic                    host_tx_sop,
    output logic                    host_tx_eop,
    output usb_proto_pkg::usb_pid_e host_tx_pid,

    // Device side
    input  logic [`USB_DATA_W-1:0]  device_rx_data,
    input  logic                    device_rx_valid,
    input  logic                    device_rx_sop,
    input  logic                    device_rx_eop,
    input  usb_proto_pkg::usb_pid_e device_rx_pid,
    input  logic                    device_rx_crc_valid,
    output logic [`USB_DATA_W-1:0]  device_tx_data,
    output logic                    device_tx_valid,
    output logic                    device_tx_sop,
    output logic                    device_tx_eop,
    output usb_proto_pkg::usb_pid_e device_tx_pid,

    // Log buffer
    output logic                    buffer_valid,
    output logic [`USB_DATA_W-1:0]  buffer_data,
    output proxy_pkg::log_flags_t   buffer_flags,
    output logic [`TS_W-1:0]        buffer_timestamp,
    input  logic                    buffer_ready,
    input  logic [`TS_W-1:0]        timestamp,

    // PHY monitor and control
    input  logic [1:0]              device_line_state,
    input  logic                    event_valid,
    input  logic [`EVT_W-1:0]       event_type,
    input  logic                    proxy_enable,
    output logic [7:0]              status_register
);

    import usb_proto_pkg::*;

    // Forwarded byte, FSM to logger
    logic                   fwd_valid;
    logic [`USB_DATA_W-1:0] fwd_data;
    logic                   fwd_sop;
    usb_pid_e               fwd_pid;
    pkt_dir_e               fwd_dir;

    usb_proxy_fsm i_usb_proxy_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .host_rx_data    (host_rx_data),
        .host_rx_valid   (host_rx_valid),
        .host_rx_sop     (host_rx_sop),
        .host_rx_eop     (host_rx_eop),
        .host_rx_pid     (host_rx_pid),
        .device_rx_data  (device_rx_data),
        .device_rx_valid (device_rx_valid),
        .device_rx_sop   (device_rx_sop),
        .device_rx_eop   (device_rx_eop),
        .device_rx_pid   (device_rx_pid),
        .proxy_enable    (proxy_enable),
        .host_tx_data    (host_tx_data),
        .host_tx_valid   (host_tx_valid),
        .host_tx_sop     (host_tx_sop),
        .host_tx_eop     (host_tx_eop),
        .host_tx_pid     (host_tx_pid),
        .device_tx_data  (device_tx_data),
        .device_tx_valid (device_tx_valid),
        .device_tx_sop   (device_tx_sop),
        .device_tx_eop   (device_tx_eop),
        .device_tx_pid   (device_tx_pid),
        .fwd_valid       (fwd_valid),
        .fwd_data        (fwd_data),
        .fwd_sop         (fwd_sop),
        .fwd_pid         (fwd_pid),
        .fwd_dir         (fwd_dir)
    );

    capture_logger i_capture_logger (
        .clk              (clk),
        .rst_n            (rst_n),
        .fwd_valid        (fwd_valid),
        .fwd_data         (fwd_data),
        .fwd_sop          (fwd_sop),
        .fwd_pid          (fwd_pid),
        .fwd_dir          (fwd_dir),
        .timestamp        (timestamp),
        .buffer_ready     (buffer_ready),
        .buffer_valid     (buffer_valid),
        .buffer_data      (buffer_data),
        .buffer_flags     (buffer_flags),
        .buffer_timestamp (buffer_timestamp)
    );

    link_status i_link_status (
        .clk                 (clk),
        .rst_n               (rst_n),
        .host_rx_valid       (host_rx_valid),
        .host_rx_eop         (host_rx_eop),
        .host_rx_crc_valid   (host_rx_crc_valid),
        .device_rx_valid     (device_rx_valid),
        .device_rx_eop       (device_rx_eop),
        .device_rx_crc_valid (device_rx_crc_valid),
        .device_line_state   (device_line_state),
        .event_valid         (event_valid),
        .event_type          (event_type),
        .proxy_enable        (proxy_enable),
        .status_register     (status_register)
    );

endmodule

// ==== source/link_status.sv ====
/* Link status tracker
   Connection, link speed and sticky CRC error, packed into the status byte */

`timescale 1ns/1ps

`include "usb_proxy_consts.svh"

module link_status (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              host_rx_valid,
    input  logic              host_rx_eop,
    input  logic              host_rx_crc_valid,
    input  logic              device_rx_valid,
    input  logic              device_rx_eop,
    input  logic              device_rx_crc_valid,

    input  logic [1:0]        device_line_state,
    input  logic              event_valid,
    input  logic [`EVT_W-1:0] event_type,
    input  logic              proxy_enable,

    output logic [7:0]        status_register
);

    import usb_proto_pkg::*;

    logic       connected;
    logic       crc_err;
    logic       enable_q;
    usb_speed_e speed;
    logic       crc_bad_now;

    // CRC verdict is only meaningful on the last beat
    assign crc_bad_now = (host_rx_valid && host_rx_eop && !host_rx_crc_valid) ||
                         (device_rx_valid && device_rx_eop && !device_rx_crc_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            connected <= 1'b0;
            crc_err   <= 1'b0;
            enable_q  <= 1'b0;
        end else begin
            connected <= |device_line_state;  // SE0 means detached
            enable_q  <= proxy_enable;
            if (crc_bad_now) begin
                crc_err <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Speed from PHY events
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speed <= SPEED_LOW;
        end else if (event_valid) begin
            case (event_type)
                `EVT_FULL_SPEED: speed <= SPEED_FULL;
                `EVT_HIGH_SPEED: speed <= SPEED_HIGH;
                `EVT_LOW_SPEED:  speed <= SPEED_LOW;
                default: ;  // Other events keep the speed
            endcase
        end
    end

    // {speed, 3'b0, enable, crc error, connected}
    assign status_register = {speed, 3'b000, enable_q, crc_err, connected};

    a_crc_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        crc_bad_now |=> status_register[1]);

endmodule

// ==== source/capture_logger.sv ====
/* Traffic capture logger
   Registers forwarded bytes into the log buffer with flags and packet timestamp */

`timescale 1ns/1ps

`include "usb_proxy_consts.svh"

module capture_logger (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    fwd_valid,
    input  logic [`USB_DATA_W-1:0]  fwd_data,
    input  logic                    fwd_sop,
    input  usb_proto_pkg::usb_pid_e fwd_pid,
    input  usb_proto_pkg::pkt_dir_e fwd_dir,

    input  logic [`TS_W-1:0]        timestamp,
    input  logic                    buffer_ready,

    output logic                    buffer_valid,
    output logic [`USB_DATA_W-1:0]  buffer_data,
    output proxy_pkg::log_flags_t   buffer_flags,
    output logic [`TS_W-1:0]        buffer_timestamp
);

    import proxy_pkg::*;

    logic [`TS_W-1:0] pkt_ts;   // Time of the current packet's SOP
    logic             accept;
    log_flags_t       flags_d;

    // Slot must be empty too, a busy slot drops the byte
    assign accept  = fwd_valid && buffer_ready && !buffer_valid;
    assign flags_d = '{pad: 3'b000, pid: fwd_pid, dir: fwd_dir};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buffer_valid <= 1'b0;
        end else begin
            buffer_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_valid && fwd_sop) begin
            pkt_ts <= timestamp;
        end
        if (accept) begin
            buffer_data  <= fwd_data;
            buffer_flags <= flags_d;
            // SOP byte takes the live value, later bytes the latched one
            buffer_timestamp <= fwd_sop ? timestamp : pkt_ts;
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        buffer_valid |=> !buffer_valid);

endmodule

// ==== source/proxy_fsm.sv ====
/* USB proxy transaction FSM
   Follows host packet, device response and host turnaround, and forwards
   the active side with zero latency */

`timescale 1ns/1ps

`include "usb_proxy_consts.svh"

module usb_proxy_fsm (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [`USB_DATA_W-1:0]  host_rx_data,
    input  logic                    host_rx_valid,
    input  logic                    host_rx_sop,
    input  logic                    host_rx_eop,
    input  usb_proto_pkg::usb_pid_e host_rx_pid,

    input  logic [`USB_DATA_W-1:0]  device_rx_data,
    input  logic                    device_rx_valid,
    input  logic                    device_rx_sop,
    input  logic                    device_rx_eop,
    input  usb_proto_pkg::usb_pid_e device_rx_pid,

    input  logic                    proxy_enable,

    output logic [`USB_DATA_W-1:0]  host_tx_data,
    output logic                    host_tx_valid,
    output logic                    host_tx_sop,
    output logic                    host_tx_eop,
    output usb_proto_pkg::usb_pid_e host_tx_pid,

    output logic [`USB_DATA_W-1:0]  device_tx_data,
    output logic                    device_tx_valid,
    output logic                    device_tx_sop,
    output logic                    device_tx_eop,
    output usb_proto_pkg::usb_pid_e device_tx_pid,

    output logic                    fwd_valid,
    output logic [`USB_DATA_W-1:0]  fwd_data,
    output logic                    fwd_sop,
    output usb_proto_pkg::usb_pid_e fwd_pid,
    output usb_proto_pkg::pkt_dir_e fwd_dir
);

    import usb_proto_pkg::*;
    import proxy_pkg::*;

    localparam int unsigned TO_W = $clog2(`RESP_TIMEOUT);
    localparam logic [TO_W-1:0] TO_LAST = TO_W'(`RESP_TIMEOUT - 1);

    proxy_state_e   state;
    proxy_state_e   state_d;
    logic [TO_W-1:0] wait_cnt;
    usb_pid_e       pkt_pid;    // PID of the packet in flight

    logic host_sop_ok;
    logic host_is_sof;
    logic dev_sop_ok;
    logic host_fwd;
    logic dev_fwd;
    logic in_wait;

    ////////////////////////////////////////////////////////////////////////////
    // Start of packet acceptance
    ////////////////////////////////////////////////////////////////////////////

    assign host_sop_ok = proxy_enable && host_rx_valid && host_rx_sop &&
                         (state == ST_IDLE || state == ST_WAIT_HOST);
    assign host_is_sof = (host_rx_pid == PID_SOF);

    // Host wins a tie in idle
    assign dev_sop_ok = device_rx_valid && device_rx_sop &&
                        ((state == ST_IDLE && proxy_enable && !host_sop_ok) ||
                         state == ST_WAIT_DEV);

    assign host_fwd = (host_sop_ok && !host_is_sof) || (state == ST_H2D && host_rx_valid);
    assign dev_fwd  = dev_sop_ok || (state == ST_D2H && device_rx_valid);

    assign in_wait = (state == ST_WAIT_DEV) || (state == ST_WAIT_HOST);

    ////////////////////////////////////////////////////////////////////////////
    // Transaction state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state;
        if (host_sop_ok) begin
            if (host_is_sof) begin
                state_d = host_rx_eop ? ST_IDLE : ST_SOF_SKIP;
            end else begin
                state_d = host_rx_eop ? ST_WAIT_DEV : ST_H2D;
            end
        end else if (dev_sop_ok) begin
            state_d = device_rx_eop ? ST_WAIT_HOST : ST_D2H;
        end else begin
            case (state)
                ST_IDLE: ;
                ST_H2D: if (host_rx_valid && host_rx_eop) state_d = ST_WAIT_DEV;
                ST_D2H: if (device_rx_valid && device_rx_eop) state_d = ST_WAIT_HOST;
                ST_WAIT_DEV, ST_WAIT_HOST: begin
                    if (wait_cnt == TO_LAST) state_d = ST_IDLE;  // Nobody answered
                end
                ST_SOF_SKIP: if (host_rx_valid && host_rx_eop) state_d = ST_IDLE;
                default: state_d = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
        end else begin
            state <= state_d;
            // Restarts on every entry into a wait state
            if (in_wait && state_d == state) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_sop_ok) begin
            pkt_pid <= host_rx_pid;
        end else if (dev_sop_ok) begin
            pkt_pid <= device_rx_pid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding paths
    ////////////////////////////////////////////////////////////////////////////

    assign device_tx_data  = host_rx_data;
    assign device_tx_valid = host_fwd;
    assign device_tx_sop   = host_fwd && host_rx_sop;
    assign device_tx_eop   = host_fwd && host_rx_eop;
    assign device_tx_pid   = host_rx_pid;

    assign host_tx_data  = device_rx_data;
    assign host_tx_valid = dev_fwd;
    assign host_tx_sop   = dev_fwd && device_rx_sop;
    assign host_tx_eop   = dev_fwd && device_rx_eop;
    assign host_tx_pid   = device_rx_pid;

    // One copy of the forwarded byte for the logger
    assign fwd_valid = host_fwd || dev_fwd;
    assign fwd_dir   = dev_fwd ? DIR_D2H : DIR_H2D;
    assign fwd_data  = dev_fwd ? device_rx_data : host_rx_data;
    assign fwd_sop   = dev_fwd ? device_rx_sop : host_rx_sop;
    assign fwd_pid   = host_sop_ok ? host_rx_pid :
                       dev_sop_ok  ? device_rx_pid : pkt_pid;

    // Half duplex bus, only one side may be driven
    a_one_tx_side: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_tx_valid && device_tx_valid));

endmodule

// ==== source/proxy_pkg.sv ====
/* Proxy internal types
   Transaction FSM states and the layout of the log flag byte */

package proxy_pkg;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_H2D       = 3'd1,  // Host packet in flight
        ST_WAIT_DEV  = 3'd2,  // Waiting for the device to answer
        ST_D2H       = 3'd3,  // Device packet in flight
        ST_WAIT_HOST = 3'd4,
        ST_SOF_SKIP  = 3'd5   // Swallowing a SOF
    } proxy_state_e;

    // Flag byte stored next to every logged data byte
    typedef struct packed {
        logic [2:0]              pad;
        usb_proto_pkg::usb_pid_e pid;
        usb_proto_pkg::pkt_dir_e dir;  // LSB
    } log_flags_t;

endpackage

// ==== source/usb_proto_pkg.sv ====
/* USB protocol types
   Packet IDs, link speed and traffic direction as seen on the bus */

`include "usb_proxy_consts.svh"

package usb_proto_pkg;

    // Standard PID codes, check bits already stripped by the PHY
    typedef enum logic [`USB_PID_W-1:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SOF   = 4'b0101,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_DATA2 = 4'b0111,
        PID_MDATA = 4'b1111,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110,
        PID_NYET  = 4'b0110
    } usb_pid_e;

    typedef enum logic [1:0] {
        SPEED_LOW  = 2'd0,  // Also unknown
        SPEED_FULL = 2'd1,
        SPEED_HIGH = 2'd2
    } usb_speed_e;

    typedef enum logic {
        DIR_H2D = 1'b0,
        DIR_D2H = 1'b1
    } pkt_dir_e;

endpackage

// ==== source/usb_proxy_consts.svh ====
/* USB proxy constants
   Data, PID and timestamp widths, response timeout and PHY event codes */

`ifndef USB_PROXY_CONSTS_SVH
`define USB_PROXY_CONSTS_SVH

// Datapath widths
`define USB_DATA_W 8
`define USB_PID_W 4
`define TS_W 64

// Cycles spent in a wait state before falling back to idle
`define RESP_TIMEOUT 200

// PHY event interface
`define EVT_W 8
`define EVT_FULL_SPEED 8'd1  // Full speed detected
`define EVT_HIGH_SPEED 8'd2  // Chirp handshake done
`define EVT_LOW_SPEED 8'd3

`endif
